// File: conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Signed pixel and weight width
`define CONV_DATA_WIDTH 8

// Kernel lanes per beat
`define CONV_STEPS 4

// One more than the cycles an accumulator cell takes
`define CONV_ACC_DELAY 3

// Guard bits above the product width cover up to 16 lanes
`define CONV_ACC_WIDTH (2 * `CONV_DATA_WIDTH + 4)

// Kernel row index and output-channel group
`define CONV_USER_WIDTH 8

`endif

// File: cnn_pkg.sv
`default_nettype none

`include "conv_macros.svh"

package cnn_pkg;

    // Full-precision pixel times weight
    typedef logic signed [2*`CONV_DATA_WIDTH-1:0] product_t;

    // Accumulated dot product
    typedef logic signed [`CONV_ACC_WIDTH-1:0] sum_t;

    // Sideband word, carried through untouched
    typedef struct packed {
        logic [`CONV_USER_WIDTH/2-1:0] kernel_row;
        logic [`CONV_USER_WIDTH/2-1:0] och_group;
    } user_t;

endpackage

`default_nettype wire

// File: lane_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

interface lane_bus_if #(
    parameter int DATA_WIDTH = 2 * `CONV_DATA_WIDTH
);

    localparam int STEPS = `CONV_STEPS;

    // One entry per kernel lane
    logic [STEPS-1:0]                 valid;
    logic [STEPS-1:0][DATA_WIDTH-1:0] data;
    logic [STEPS-1:0]                 last;
    cnn_pkg::user_t [STEPS-1:0]       user;

    // No ready: the shared aclken stalls every stage at once
    modport source (
        output valid,
        output data,
        output last,
        output user
    );

    modport sink (
        input valid,
        input data,
        input last,
        input user
    );

endinterface

`default_nettype wire

// File: n_delay.sv
`timescale 1ns/1ps
`default_nettype none

module n_delay #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  wire              aclk,
    input  wire              aclken,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    if (DEPTH == 0) begin : g_wire
        assign data_out = data_in;
    end else begin : g_shift
        logic [WIDTH-1:0] stages [DEPTH];

        always_ff @(posedge aclk) begin
            if (!rst_n) begin
                for (int k = 0; k < DEPTH; k++) begin
                    stages[k] <= '0;
                end
            end else if (aclken) begin
                stages[0] <= data_in;
                for (int k = 1; k < DEPTH; k++) begin
                    stages[k] <= stages[k-1];
                end
            end
        end

        assign data_out = stages[DEPTH-1];
    end

endmodule

`default_nettype wire

// File: mult_lanes.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module mult_lanes (
    input  wire                                     aclk,
    input  wire                                     aclken,
    input  wire                                     rst_n,
    input  wire                                     s_valid,
    input  wire [`CONV_STEPS*`CONV_DATA_WIDTH-1:0]  s_pixels,
    input  wire [`CONV_STEPS*`CONV_DATA_WIDTH-1:0]  s_weights,
    input  wire                                     s_last,
    input  wire cnn_pkg::user_t                     s_user,
    lane_bus_if.source                              prod
);

    localparam int STEPS = `CONV_STEPS;
    localparam int DW    = `CONV_DATA_WIDTH;

    cnn_pkg::product_t [STEPS-1:0] product;

    for (genvar i = 0; i < STEPS; i++) begin : g_lane
        logic signed [DW-1:0] pixel;
        logic signed [DW-1:0] weight;

        assign pixel  = s_pixels[i*DW +: DW];
        assign weight = s_weights[i*DW +: DW];

        // Both operands signed, so the product is widened before the multiply
        assign product[i] = pixel * weight;
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            prod.valid <= '0;
            prod.data  <= '0;
            prod.last  <= '0;
            prod.user  <= '0;
        end else if (aclken) begin
            // Beat flags are shared, every lane takes its own copy
            prod.valid <= {STEPS{s_valid}};
            prod.data  <= product;
            prod.last  <= {STEPS{s_last}};
            prod.user  <= {STEPS{s_user}};
        end
    end

endmodule

`default_nettype wire

// File: step_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module step_buffer (
    input  wire        aclk,
    input  wire        aclken,
    input  wire        rst_n,
    input  wire        is_1x1,
    lane_bus_if.sink   s,
    lane_bus_if.source m
);

    localparam int STEPS = `CONV_STEPS;
    localparam int DW    = 2 * `CONV_DATA_WIDTH;
    localparam int CELL  = `CONV_ACC_DELAY - 1;
    localparam int UW    = `CONV_USER_WIDTH;

    logic [STEPS-1:0]           hold_valid;
    logic [STEPS-1:0][DW-1:0]   hold_data;
    logic [STEPS-1:0]           hold_last;
    cnn_pkg::user_t [STEPS-1:0] hold_user;

    // Lane 0 meets the first accumulator cell without skew
    assign hold_valid[0] = s.valid[0];
    assign hold_data[0]  = s.data[0];
    assign hold_last[0]  = s.last[0];
    assign hold_user[0]  = s.user[0];

    // Lane i waits for the i cells ahead of it in the chain
    for (genvar i = 1; i < STEPS; i++) begin : g_skew
        logic           dly_valid;
        logic [DW-1:0]  dly_data;
        logic           dly_last;
        cnn_pkg::user_t dly_user;

        n_delay #(.DEPTH(i * CELL), .WIDTH(1)) delay_valid (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(s.valid[i]), .data_out(dly_valid)
        );

        n_delay #(.DEPTH(i * CELL), .WIDTH(DW)) delay_data (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(s.data[i]), .data_out(dly_data)
        );

        n_delay #(.DEPTH(i * CELL), .WIDTH(1)) delay_last (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(s.last[i]), .data_out(dly_last)
        );

        n_delay #(.DEPTH(i * CELL), .WIDTH(UW)) delay_user (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(s.user[i]), .data_out(dly_user)
        );

        // 1x1 lanes are independent and skip the skew
        assign hold_valid[i] = is_1x1 ? s.valid[i] : dly_valid;
        assign hold_data[i]  = is_1x1 ? s.data[i]  : dly_data;
        assign hold_last[i]  = is_1x1 ? s.last[i]  : dly_last;
        assign hold_user[i]  = is_1x1 ? s.user[i]  : dly_user;
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m.valid <= '0;
            m.data  <= '0;
            m.last  <= '0;
            m.user  <= '0;
        end else if (aclken) begin
            m.valid <= hold_valid;
            m.data  <= hold_data;
            m.last  <= hold_last;
            m.user  <= hold_user;
        end
    end

endmodule

`default_nettype wire

// File: accumulator_chain.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module accumulator_chain (
    input  wire                                    aclk,
    input  wire                                    aclken,
    input  wire                                    rst_n,
    input  wire                                    is_1x1,
    lane_bus_if.sink                               s,
    output logic [`CONV_STEPS-1:0]                 m_valid,
    output logic [`CONV_STEPS*`CONV_ACC_WIDTH-1:0] m_sums,
    output logic                                   m_last,
    output cnn_pkg::user_t                         m_user
);

    localparam int STEPS = `CONV_STEPS;
    localparam int AW    = `CONV_ACC_WIDTH;
    localparam int CELL  = `CONV_ACC_DELAY - 1;
    localparam int UW    = `CONV_USER_WIDTH;

    // Delayed cell outputs, also the partial sums for the next cell
    cnn_pkg::sum_t [STEPS-1:0] cell_sum;
    logic [STEPS-1:0]          cell_valid;

    for (genvar i = 0; i < STEPS; i++) begin : g_cell
        localparam bit IS_TAIL = (i == STEPS - 1);

        cnn_pkg::product_t lane_prod;
        cnn_pkg::sum_t     partial;
        cnn_pkg::sum_t     sum_in;
        logic              valid_in;

        assign lane_prod = s.data[i];

        if (i == 0) begin : g_head
            assign partial = '0;
        end else begin : g_link
            // Skewed lane i arrives together with the sum of cell i-1
            assign partial = is_1x1 ? cnn_pkg::sum_t'(0) : cell_sum[i-1];
        end

        assign sum_in = cnn_pkg::sum_t'(lane_prod) + partial;

        // Partial sums are not results unless lanes stand alone
        assign valid_in = s.valid[i] & (is_1x1 | IS_TAIL);

        n_delay #(.DEPTH(CELL), .WIDTH(AW)) delay_sum (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(sum_in), .data_out(cell_sum[i])
        );

        n_delay #(.DEPTH(CELL), .WIDTH(1)) delay_valid (
            .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
            .data_in(valid_in), .data_out(cell_valid[i])
        );
    end

    // Sideband of the final lane rides along with the final result
    n_delay #(.DEPTH(CELL), .WIDTH(1)) delay_last (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
        .data_in(s.last[STEPS-1]), .data_out(m_last)
    );

    n_delay #(.DEPTH(CELL), .WIDTH(UW)) delay_user (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n),
        .data_in(s.user[STEPS-1]), .data_out(m_user)
    );

    assign m_sums  = cell_sum;
    assign m_valid = cell_valid;

endmodule

`default_nettype wire

// File: conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_engine (
    input  wire                                    aclk,
    input  wire                                    aclken,
    input  wire                                    rst_n,
    input  wire                                    is_1x1,
    input  wire                                    s_valid,
    input  wire [`CONV_STEPS*`CONV_DATA_WIDTH-1:0] s_pixels,
    input  wire [`CONV_STEPS*`CONV_DATA_WIDTH-1:0] s_weights,
    input  wire                                    s_last,
    input  wire cnn_pkg::user_t                    s_user,
    output logic [`CONV_STEPS-1:0]                 m_valid,
    output logic [`CONV_STEPS*`CONV_ACC_WIDTH-1:0] m_sums,
    output logic                                   m_last,
    output cnn_pkg::user_t                         m_user
);

    // Products from the multipliers
    lane_bus_if #(.DATA_WIDTH(2 * `CONV_DATA_WIDTH)) prod_bus ();

    // Products skewed to meet the accumulator chain
    lane_bus_if #(.DATA_WIDTH(2 * `CONV_DATA_WIDTH)) skew_bus ();

    mult_lanes mult_lanes_i (
        .aclk      (aclk),
        .aclken    (aclken),
        .rst_n     (rst_n),
        .s_valid   (s_valid),
        .s_pixels  (s_pixels),
        .s_weights (s_weights),
        .s_last    (s_last),
        .s_user    (s_user),
        .prod      (prod_bus.source)
    );

    step_buffer step_buffer_i (
        .aclk   (aclk),
        .aclken (aclken),
        .rst_n  (rst_n),
        .is_1x1 (is_1x1),
        .s      (prod_bus.sink),
        .m      (skew_bus.source)
    );

    accumulator_chain accumulator_chain_i (
        .aclk    (aclk),
        .aclken  (aclken),
        .rst_n   (rst_n),
        .is_1x1  (is_1x1),
        .s       (skew_bus.sink),
        .m_valid (m_valid),
        .m_sums  (m_sums),
        .m_last  (m_last),
        .m_user  (m_user)
    );

endmodule

`default_nettype wire

// File: conv_engine_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_engine_checker (
    input wire                                    aclk,
    input wire                                    aclken,
    input wire                                    rst_n,
    input wire                                    is_1x1,
    input wire [`CONV_STEPS-1:0]                  m_valid,
    input wire [`CONV_STEPS*`CONV_ACC_WIDTH-1:0]  m_sums,
    input wire                                    m_last,
    input wire cnn_pkg::user_t                    m_user
);

    localparam int STEPS = `CONV_STEPS;

    int failures = 0;

    // Synchronous reset clears every result flag on the next edge
    reset_clears_valid: assert property (@(posedge aclk) !rst_n |=> m_valid == '0)
        else begin
            $error("m_valid still set after a reset edge");
            failures++;
        end

    // Partial sums never show up as results
    single_result_in_normal: assert property (@(posedge aclk) disable iff (!rst_n)
        !is_1x1 |-> m_valid[STEPS-2:0] == '0)
        else begin
            $error("m_valid set on an inner lane in normal mode");
            failures++;
        end

    frozen_while_disabled: assert property (@(posedge aclk) disable iff (!rst_n)
        !aclken |=> $stable(m_valid) && $stable(m_sums) && $stable(m_last) && $stable(m_user))
        else begin
            $error("outputs changed on an edge with aclken low");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb_conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module tb_conv_engine;

    localparam int STEPS       = `CONV_STEPS;
    localparam int DW          = `CONV_DATA_WIDTH;
    localparam int AW          = `CONV_ACC_WIDTH;
    localparam int CELL        = `CONV_ACC_DELAY - 1;
    localparam int LAT_NORMAL  = 2 + STEPS * CELL;
    localparam int LAT_1X1     = 2 + CELL;
    localparam int STALL_LIMIT = 64;
    localparam int DRAIN_LIMIT = 200;

    typedef struct packed {
        logic [STEPS-1:0]    mask;
        logic [STEPS*AW-1:0] sums;
        logic                last;
        cnn_pkg::user_t      user;
        int                  stamp;
        int                  latency;
    } expect_t;

    logic                aclk;
    logic                aclken;
    logic                rst_n;
    logic                is_1x1;
    logic                s_valid;
    logic [STEPS*DW-1:0] s_pixels;
    logic [STEPS*DW-1:0] s_weights;
    logic                s_last;
    cnn_pkg::user_t      s_user;
    logic [STEPS-1:0]    m_valid;
    logic [STEPS*AW-1:0] m_sums;
    logic                m_last;
    cnn_pkg::user_t      m_user;

    integer  seed = 32'h5650;
    expect_t exp_q [$];
    int      edge_count;
    logic    edge_enabled;
    logic    stall_on;

    conv_engine conv_engine_i (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .is_1x1(is_1x1),
        .s_valid(s_valid), .s_pixels(s_pixels), .s_weights(s_weights),
        .s_last(s_last), .s_user(s_user),
        .m_valid(m_valid), .m_sums(m_sums), .m_last(m_last), .m_user(m_user)
    );

    bind conv_engine conv_engine_checker checker_i (
        .aclk(aclk), .aclken(aclken), .rst_n(rst_n), .is_1x1(is_1x1),
        .m_valid(m_valid), .m_sums(m_sums), .m_last(m_last), .m_user(m_user)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR: %s got 0x%h expected 0x%h", name, got, expected);
            abort_run();
        end
    endtask

    // Dot product on the last lane, or one independent product per lane in 1x1 mode
    function automatic logic [STEPS*AW-1:0] reference_sums(input logic [STEPS*DW-1:0] pixels,
                                                           input logic [STEPS*DW-1:0] weights,
                                                           input logic one_by_one);
        logic [STEPS*AW-1:0] result;
        int                  prod;
        int                  total;
        result = '0;
        total  = 0;
        for (int i = 0; i < STEPS; i++) begin
            prod  = int'($signed(pixels[i*DW +: DW])) * int'($signed(weights[i*DW +: DW]));
            total = total + prod;
            if (one_by_one) begin
                result[i*AW +: AW] = prod[AW-1:0];
            end
        end
        if (!one_by_one) begin
            result[(STEPS-1)*AW +: AW] = total[AW-1:0];
        end
        return result;
    endfunction

    function automatic logic [STEPS*DW-1:0] random_lanes();
        logic [STEPS*DW-1:0] lanes;
        logic [31:0]         r;
        for (int i = 0; i < STEPS; i++) begin
            r = $random(seed);
            lanes[i*DW +: DW] = r[DW-1:0];
        end
        return lanes;
    endfunction

    function automatic logic [STEPS*DW-1:0] lane_pattern(input int even_val, input int odd_val);
        logic [STEPS*DW-1:0] lanes;
        for (int i = 0; i < STEPS; i++) begin
            lanes[i*DW +: DW] = (i % 2 == 0) ? even_val[DW-1:0] : odd_val[DW-1:0];
        end
        return lanes;
    endfunction

    // Holds the beat on the inputs until an enabled edge takes it
    task automatic send_beat(input logic valid, input logic [STEPS*DW-1:0] pixels,
                             input logic [STEPS*DW-1:0] weights, input logic last,
                             input cnn_pkg::user_t user);
        logic [31:0] r;
        logic        taken;
        int          stalls;
        s_valid   = valid;
        s_pixels  = pixels;
        s_weights = weights;
        s_last    = last;
        s_user    = user;
        taken     = 1'b0;
        stalls    = 0;
        while (!taken) begin
            r      = $random(seed);
            aclken = !(stall_on && r[1:0] == 2'b00);
            @(posedge aclk);
            #1;
            taken  = aclken;
            stalls++;
            if (stalls > STALL_LIMIT) begin
                $display("aclken stayed low too long and the beat was never taken");
                abort_run();
            end
        end
    endtask

    task automatic send_random_beat(input logic valid);
        logic [31:0] r;
        r = $random(seed);
        send_beat(valid, random_lanes(), random_lanes(), r[0],
                  cnn_pkg::user_t'(r[8 +: `CONV_USER_WIDTH]));
    endtask

    task automatic send_corner_beats();
        send_beat(1'b1, lane_pattern(-128, -128), lane_pattern(-128, -128), 1'b0, 8'h11);
        send_beat(1'b1, lane_pattern(-128, -128), lane_pattern(127, 127), 1'b0, 8'h22);
        send_beat(1'b1, lane_pattern(127, 127), lane_pattern(127, 127), 1'b0, 8'h33);
        send_beat(1'b1, lane_pattern(-128, 127), lane_pattern(-128, -128), 1'b0, 8'h44);
        send_beat(1'b1, lane_pattern(-1, -1), lane_pattern(1, 1), 1'b0, 8'h55);
        send_beat(1'b1, lane_pattern(0, -128), lane_pattern(-128, 0), 1'b1, 8'h66);
    endtask

    task automatic drain_pipeline();
        int waited;
        s_valid = 1'b0;
        aclken  = 1'b1;
        waited  = 0;
        while (exp_q.size() != 0) begin
            @(posedge aclk);
            #1;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("No output arrived for %0d outstanding beats", exp_q.size());
                abort_run();
            end
        end
        // Stale flags in the skew lines must clear before is_1x1 may change
        repeat (2 * LAT_NORMAL) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic compare_result();
        expect_t entry;
        if (exp_q.size() == 0) begin
            $display("m_valid was set while no beat was outstanding");
            abort_run();
        end else begin
            entry = exp_q.pop_front();
            check_value("m_valid latency", 32'(edge_count - entry.stamp), 32'(entry.latency));
            check_value("m_valid", 32'(m_valid), 32'(entry.mask));
            for (int i = 0; i < STEPS; i++) begin
                if (entry.mask[i]) begin
                    check_value($sformatf("m_sums[%0d]", i), 32'(m_sums[i*AW +: AW]),
                                32'(entry.sums[i*AW +: AW]));
                end
            end
            check_value("m_last", 32'(m_last), 32'(entry.last));
            check_value("m_user", 32'(m_user), 32'(entry.user));
        end
    endtask

    // Inputs are sampled on enabled edges and valid beats go to the scoreboard
    initial begin
        expect_t entry;
        forever begin
            @(posedge aclk);
            edge_enabled = rst_n && aclken;
            if (edge_enabled) begin
                if (s_valid) begin
                    entry.sums = reference_sums(s_pixels, s_weights, is_1x1);
                    entry.mask = '0;
                    if (is_1x1) begin
                        entry.mask = '1;
                    end else begin
                        entry.mask[STEPS-1] = 1'b1;
                    end
                    entry.last    = s_last;
                    entry.user    = s_user;
                    // The edge that takes the beat counts toward its latency
                    entry.stamp   = edge_count;
                    entry.latency = is_1x1 ? LAT_1X1 : LAT_NORMAL;
                    exp_q.push_back(entry);
                end
                edge_count++;
            end
        end
    end

    // Outputs are stable at the falling edge
    initial begin
        forever begin
            @(negedge aclk);
            if (edge_enabled === 1'b1) begin
                if (m_valid != '0) begin
                    compare_result();
                end else if (exp_q.size() != 0 &&
                             edge_count - exp_q[0].stamp >= exp_q[0].latency) begin
                    $display("No output arrived for the beat taken at enabled edge %0d",
                             exp_q[0].stamp);
                    abort_run();
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        aclken       = 1'b1;
        rst_n        = 1'b0;
        is_1x1       = 1'b0;
        s_valid      = 1'b0;
        s_pixels     = '0;
        s_weights    = '0;
        s_last       = 1'b0;
        s_user       = '0;
        stall_on     = 1'b0;
        edge_count   = 0;
        edge_enabled = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        repeat (40) send_random_beat(1'b1);
        send_corner_beats();
        drain_pipeline();

        stall_on = 1'b1;
        repeat (40) send_random_beat(1'b1);
        stall_on = 1'b0;
        repeat (40) begin
            r = $random(seed);
            send_random_beat(r[0]);
        end
        drain_pipeline();

        is_1x1 = 1'b1;
        repeat (30) send_random_beat(1'b1);
        send_corner_beats();
        stall_on = 1'b1;
        repeat (30) begin
            r = $random(seed);
            send_random_beat(r[0]);
        end
        stall_on = 1'b0;
        drain_pipeline();

        is_1x1 = 1'b0;
        repeat (10) send_random_beat(1'b1);
        drain_pipeline();

        if (conv_engine_i.checker_i.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures in the checker", conv_engine_i.checker_i.failures);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
cnn_pkg.sv
lane_bus_if.sv
n_delay.sv
mult_lanes.sv
step_buffer.sv
accumulator_chain.sv
conv_engine.sv
conv_engine_checker.sv
tb_conv_engine.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_conv_engine
FILELIST   = filelist.f
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
BUILD      = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides pass or fail, the run itself may stop early on an error
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
